/* build.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_extract.sv
design/flow_detect.sv
design/pipeline_mux.sv
test/pipeline_mux_properties.sv
test/tb_pipeline_mux.sv

/* design/fetch_extract.sv */
// First mux stage, aligns a fetched cache line to the PC and registers four qualified slots

`timescale 1ns/1ps

module fetch_extract (
	input  logic                         clk,
	input  logic                         rst_i,
	input  logic                         fetch_i,
	input  isa_pkg::pc_t                 pc_i,
	input  logic [isa_pkg::LINE_W-1:0]   line_i,
	input  logic                         ssm_i,
	input  logic                         irq_i,
	input  logic                         stomp_i,
	input  logic                         branchmiss_i,
	input  isa_pkg::pc_t                 miss_pc_i,
	output logic                         grp_valid_o,
	output pipe_pkg::group_t             group_o
);

	// ========================================================================
	// Line alignment
	// ========================================================================

	// Parcel index of the fetch PC within the line
	logic [isa_pkg::PARCEL_IDX_HI-isa_pkg::PARCEL_IDX_LO:0] parcel_idx;

	// The line with a full line of NOP parcels stacked above it
	logic [2*isa_pkg::LINE_W-1:0] padded_line;
	logic [2*isa_pkg::LINE_W-1:0] shifted_line;

	// Low bits of the shifted line, enough for every slot of the group
	logic [isa_pkg::ALIGN_W-1:0] aligned;

	assign parcel_idx = pc_i[isa_pkg::PARCEL_IDX_HI:isa_pkg::PARCEL_IDX_LO];

	// Slots that run past the end of the line pick up NOP parcels from the pad
	assign padded_line = {{(isa_pkg::LINE_W/isa_pkg::PARCEL_W){isa_pkg::NOP_PARCEL}}, line_i};

	// Moving right by whole parcels puts the PC's parcel at bit zero
	assign shifted_line = padded_line >> (parcel_idx * isa_pkg::PARCEL_W);

	assign aligned = shifted_line[isa_pkg::ALIGN_W-1:0];

	// ========================================================================
	// Previous strobe memory
	// ========================================================================

	isa_pkg::pc_t prev_pc;
	logic [isa_pkg::ALIGN_W-1:0] prev_aligned;
	logic prev_ssm;

	// Group qualifiers derived from the current strobe and the one before
	logic redundant;
	logic kill_all;
	logic ssm_rise;
	logic ssm_hold;

	// A refetch of the same PC with identical bits would issue the group twice
	assign redundant = (prev_pc == pc_i) && (prev_aligned == aligned);

	// These conditions discard the whole group regardless of slot position
	assign kill_all = redundant || irq_i || stomp_i;

	// First strobe with single step enabled lets exactly one instruction through
	assign ssm_rise = ssm_i && !prev_ssm;

	// Later strobes in single step issue nothing until the mode is left
	assign ssm_hold = ssm_i && prev_ssm;

	// ========================================================================
	// Slot extraction and qualification
	// ========================================================================

	pipe_pkg::group_t group_next;

	always_comb begin
		isa_pkg::pc_t slot_pc;
		group_next = '0;
		for (int k = 0; k < isa_pkg::SLOTS; k++) begin
			// Each slot sits one instruction length past the one before it
			slot_pc = pc_i + isa_pkg::pc_t'(k * isa_pkg::INSN_BYTES);
			group_next.slot[k].pc = slot_pc;
			group_next.slot[k].insn = aligned[k*isa_pkg::INSN_W +: isa_pkg::INSN_W];
			group_next.slot[k].ssm = 1'b0;

			// Instructions below the branch miss target lie on the wrong path
			group_next.slot[k].valid = !kill_all && !(branchmiss_i && (miss_pc_i > slot_pc));

			// Single step replaces slots with invalid NOPs that carry the ssm mark
			// On the rising edge slot 0 is spared and keeps its instruction
			if (ssm_hold || (ssm_rise && (k != 0))) begin
				group_next.slot[k].insn = isa_pkg::NOP_INSN;
				group_next.slot[k].ssm = 1'b1;
				group_next.slot[k].valid = 1'b0;
			end
		end
	end

	// ========================================================================
	// Registers
	// ========================================================================

	// Control state and the redundancy memory
	always_ff @(posedge clk) begin
		if (rst_i) begin
			grp_valid_o <= 1'b0;
			prev_pc <= '0;
			prev_aligned <= '0;
			prev_ssm <= 1'b0;
		end else begin
			// One group leaves this stage for every fetch strobe
			grp_valid_o <= fetch_i;
			if (fetch_i) begin
				prev_pc <= pc_i;
				prev_aligned <= aligned;
				prev_ssm <= ssm_i;
			end
		end
	end

	// Group payload loads only on a strobe and holds otherwise
	always_ff @(posedge clk) begin
		if (fetch_i) begin
			group_o <= group_next;
		end
	end

endmodule

/* design/flow_detect.sv */
// Second mux stage, finds the first call, branch or return in a slot group and registers it

`timescale 1ns/1ps

module flow_detect (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              grp_valid_i,
	input  pipe_pkg::group_t  group_i,
	output logic              out_valid_o,
	output pipe_pkg::group_t  group_o,
	output pipe_pkg::flow_t   flow_o
);

	// ========================================================================
	// Per slot decode
	// ========================================================================

	// Decode one slot on its own, ignoring the rest of the group
	// An invalid slot never reports a flow change
	function automatic pipe_pkg::flow_t decode_slot(input pipe_pkg::slot_t s);
		pipe_pkg::flow_t f;
		isa_pkg::opcode_e opc;
		logic [isa_pkg::DISP_W-1:0] disp;
		isa_pkg::pc_t disp_ext;
		f = pipe_pkg::FLOW_IDLE;
		opc = isa_pkg::opcode_e'(s.insn[isa_pkg::OPC_W-1:0]);
		disp = s.insn[isa_pkg::INSN_W-1:isa_pkg::DISP_LO];

		// Displacement is a signed byte offset from the slot's own PC
		disp_ext = {{(isa_pkg::PC_W-isa_pkg::DISP_W){disp[isa_pkg::DISP_W-1]}}, disp};

		if (s.valid) begin
			case (opc)
				isa_pkg::OP_BSR: begin
					f.do_bsr = 1'b1;
					f.do_call = 1'b1;
					f.target = s.pc + disp_ext;
					f.ret_pc = s.pc + isa_pkg::pc_t'(isa_pkg::INSN_BYTES);
				end
				isa_pkg::OP_JSR: begin
					// Absolute target, the full top of the instruction
					f.do_bsr = 1'b1;
					f.do_call = 1'b1;
					f.target = s.insn[isa_pkg::INSN_W-1:isa_pkg::JSR_LO];
					f.ret_pc = s.pc + isa_pkg::pc_t'(isa_pkg::INSN_BYTES);
				end
				isa_pkg::OP_BCC: begin
					// Conditional branch changes the PC but pushes no return address
					f.do_bsr = 1'b1;
					f.target = s.pc + disp_ext;
				end
				isa_pkg::OP_RET: begin
					// The return target comes from the return stack, not from here
					f.do_ret = 1'b1;
				end
				default: begin
					f = pipe_pkg::FLOW_IDLE;
				end
			endcase
		end
		return f;
	endfunction

	// ========================================================================
	// Priority scan
	// ========================================================================

	pipe_pkg::flow_t flow_next;

	// Only the earliest flow change counts, later slots are on a dead path
	always_comb begin
		pipe_pkg::flow_t cand;
		logic found;
		flow_next = pipe_pkg::FLOW_IDLE;
		found = 1'b0;
		for (int k = 0; k < isa_pkg::SLOTS; k++) begin
			cand = decode_slot(group_i.slot[k]);
			if (!found && (cand.do_bsr || cand.do_ret)) begin
				found = 1'b1;
				flow_next = cand;
			end
		end
	end

	// ========================================================================
	// Registers
	// ========================================================================

	// Strobe and flow flags return to idle on reset
	always_ff @(posedge clk) begin
		if (rst_i) begin
			out_valid_o <= 1'b0;
			flow_o <= pipe_pkg::FLOW_IDLE;
		end else begin
			out_valid_o <= grp_valid_i;
			if (grp_valid_i) begin
				flow_o <= flow_next;
			end
		end
	end

	// Group moves along with its flow result in the same cycle
	always_ff @(posedge clk) begin
		if (grp_valid_i) begin
			group_o <= group_i;
		end
	end

endmodule

/* design/isa_pkg.sv */
// Instruction set and cache line geometry shared by the fetch mux RTL and its testbench

package isa_pkg;

	// ========================================================================
	// Address and line geometry
	// ========================================================================

	// Program counter width in bits
	localparam int PC_W = 32;

	// Instruction cache line width in bits
	localparam int LINE_W = 512;

	// Instructions are built from 16-bit parcels
	localparam int PARCEL_W = 16;

	// Every instruction is three parcels long
	localparam int INSN_W = 48;
	localparam int INSN_BYTES = 6;

	// Slots extracted per fetch group
	localparam int SLOTS = 4;

	// Aligned bits needed to cover all slots of a group
	localparam int ALIGN_W = SLOTS * INSN_W;

	// PC bits that pick the parcel inside the line
	localparam int PARCEL_IDX_LO = 1;
	localparam int PARCEL_IDX_HI = 5;

	typedef logic [PC_W-1:0] pc_t;

	// Fetch address used after reset and when no flow change is found
	localparam pc_t RESET_PC = 32'hFFFC_0000;

	// ========================================================================
	// Instruction fields
	// ========================================================================

	// The opcode sits in the low bits of the first parcel
	localparam int OPC_W = 7;

	typedef enum logic [OPC_W-1:0] {
		OP_NOP = 7'h1F,
		OP_ADD = 7'h04,
		OP_BSR = 7'h20,
		OP_JSR = 7'h21,
		OP_BCC = 7'h28,
		OP_RET = 7'h2C
	} opcode_e;

	// Signed byte displacement of BSR and BCC, top 24 bits of the instruction
	localparam int DISP_LO = 24;
	localparam int DISP_W = INSN_W - DISP_LO;

	// JSR carries a full absolute target in the top 32 bits
	localparam int JSR_LO = 16;

	// Filler parcel placed above the end of the line
	localparam logic [PARCEL_W-1:0] NOP_PARCEL = {{(PARCEL_W-OPC_W){1'b0}}, OP_NOP};

	// A whole instruction built only from filler parcels
	localparam logic [INSN_W-1:0] NOP_INSN = {(INSN_W/PARCEL_W){NOP_PARCEL}};

endpackage

/* design/pipe_pkg.sv */
// Packed records carried between the fetch mux stages and onto the top level ports

package pipe_pkg;

	// ========================================================================
	// Instruction slot
	// ========================================================================

	// One extracted instruction with the address it was fetched from
	// Slots marked invalid still carry their PC so later stages can follow them
	typedef struct packed {
		logic [isa_pkg::INSN_W-1:0] insn;
		isa_pkg::pc_t pc;
		logic valid;
		// Set on slots that were replaced because of single-step mode
		logic ssm;
	} slot_t;

	// ========================================================================
	// Fetch group
	// ========================================================================

	// Slot 0 is the instruction at the fetch PC, the rest follow in order
	typedef struct packed {
		slot_t [isa_pkg::SLOTS-1:0] slot;
	} group_t;

	// ========================================================================
	// Control flow result
	// ========================================================================

	// do_bsr covers every PC change found ahead of decode
	// do_call marks the subset that also pushes a return address
	typedef struct packed {
		logic do_bsr;
		logic do_call;
		logic do_ret;
		isa_pkg::pc_t target;
		isa_pkg::pc_t ret_pc;
	} flow_t;

	// Result reported when a group holds no control flow instruction
	localparam flow_t FLOW_IDLE = '{
		do_bsr:  1'b0,
		do_call: 1'b0,
		do_ret:  1'b0,
		target:  isa_pkg::RESET_PC,
		ret_pc:  isa_pkg::RESET_PC
	};

endpackage

/* design/pipeline_mux.sv */
// Top of the instruction mux, chains extraction and flow detection into a two cycle pipe

`timescale 1ns/1ps

module pipeline_mux (
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        fetch_i,
	input  isa_pkg::pc_t                pc_i,
	input  logic [isa_pkg::LINE_W-1:0]  line_i,
	input  logic                        ssm_i,
	input  logic                        irq_i,
	input  logic                        stomp_i,
	input  logic                        branchmiss_i,
	input  isa_pkg::pc_t                miss_pc_i,
	output logic                        out_valid_o,
	output pipe_pkg::group_t            group_o,
	output logic                        do_bsr_o,
	output logic                        do_call_o,
	output logic                        do_ret_o,
	output isa_pkg::pc_t                target_o,
	output isa_pkg::pc_t                ret_pc_o
);

	// Group between the stages, valid one cycle after the fetch strobe
	logic grp_valid;
	pipe_pkg::group_t group_mid;

	// Registered flow result, aligned with out_valid_o
	pipe_pkg::flow_t flow;

	fetch_extract fetch_extract_i (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_i      (fetch_i),
		.pc_i         (pc_i),
		.line_i       (line_i),
		.ssm_i        (ssm_i),
		.irq_i        (irq_i),
		.stomp_i      (stomp_i),
		.branchmiss_i (branchmiss_i),
		.miss_pc_i    (miss_pc_i),
		.grp_valid_o  (grp_valid),
		.group_o      (group_mid)
	);

	flow_detect flow_detect_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.grp_valid_i (grp_valid),
		.group_i     (group_mid),
		.out_valid_o (out_valid_o),
		.group_o     (group_o),
		.flow_o      (flow)
	);

	// Flow record spread onto individual ports
	assign do_bsr_o = flow.do_bsr;
	assign do_call_o = flow.do_call;
	assign do_ret_o = flow.do_ret;
	assign target_o = flow.target;
	assign ret_pc_o = flow.ret_pc;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run, passing only if the simulation prints the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_pipeline_mux -f build.f -o sim_pipeline_mux \
	&& ./obj_dir/sim_pipeline_mux | tee /dev/stderr | grep -qx "TEST OK" \
	&& exit 0 || exit 1

/* test/pipeline_mux_properties.sv */
// Concurrent checks bound into the mux top level for reset state, flow flags and latency

`timescale 1ns/1ps

module pipeline_mux_properties (
	input logic clk,
	input logic rst_i,
	input logic fetch_i,
	input logic out_valid_i,
	input logic do_bsr_i,
	input logic do_call_i,
	input logic do_ret_i
);

	// No group may leave the pipe in the cycle that follows reset
	reset_idle: assert property (@(posedge clk) rst_i |=> !out_valid_i)
		else $error("out_valid_o set in the cycle after reset");

	// A branch and a return cannot both be the first flow instruction
	one_flow: assert property (@(posedge clk) disable iff (rst_i) !(do_bsr_i && do_ret_i))
		else $error("do_bsr_o and do_ret_o set together");

	// Calls are a subset of PC changes
	call_is_bsr: assert property (@(posedge clk) disable iff (rst_i) do_call_i |-> do_bsr_i)
		else $error("do_call_o set without do_bsr_o");

	// Fixed two cycle latency with one output per fetch
	latency: assert property (@(posedge clk) disable iff (rst_i) out_valid_i == $past(fetch_i, 2))
		else $error("out_valid_o does not follow fetch_i by two cycles");

endmodule

bind pipeline_mux pipeline_mux_properties pipeline_mux_properties_i (
	.clk         (clk),
	.rst_i       (rst_i),
	.fetch_i     (fetch_i),
	.out_valid_i (out_valid_o),
	.do_bsr_i    (do_bsr_o),
	.do_call_i   (do_call_o),
	.do_ret_i    (do_ret_o)
);

/* test/tb_pipeline_mux.sv */
// Testbench for the instruction mux, drives random fetch groups and checks them against a model

`timescale 1ns/1ps

module tb_pipeline_mux;

	// ========================================================================
	// Test length and stimulus constants
	// ========================================================================

	localparam int SWEEP_TESTS = 32;
	localparam int DIRECT_TESTS = 4;
	localparam int RANDOM_TESTS = 400;
	localparam int NUM_TESTS = SWEEP_TESTS + DIRECT_TESTS + RANDOM_TESTS;
	localparam int CLK_PERIOD = 100;

	// Each test takes at most three cycles, the rest covers reset and drain
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 3 + 40;
	localparam int LINE_PARCELS = isa_pkg::LINE_W / isa_pkg::PARCEL_W;
	localparam logic [31:0] LFSR_SEED = 32'hda3d_4e3c;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	// One expected output group with the cycle it is due in
	typedef struct packed {
		logic [31:0] due;
		pipe_pkg::flow_t flow;
		pipe_pkg::group_t grp;
	} expect_t;

	logic clk;
	logic rst_i;
	logic fetch_i;
	isa_pkg::pc_t pc_i;
	logic [isa_pkg::LINE_W-1:0] line_i;
	logic ssm_i;
	logic irq_i;
	logic stomp_i;
	logic branchmiss_i;
	isa_pkg::pc_t miss_pc_i;
	logic out_valid_o;
	pipe_pkg::group_t group_o;
	logic do_bsr_o;
	logic do_call_o;
	logic do_ret_o;
	isa_pkg::pc_t target_o;
	isa_pkg::pc_t ret_pc_o;

	logic [31:0] lfsr;
	logic [31:0] cycle;
	int errors;
	int checks;
	expect_t exp_q[$];

	// Model copy of the previous strobe
	isa_pkg::pc_t m_prev_pc;
	logic [isa_pkg::ALIGN_W-1:0] m_prev_bits;
	logic m_prev_ssm;

	pipeline_mux pipeline_mux_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// ========================================================================
	// Random source
	// ========================================================================

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) return (s >> 1) ^ LFSR_TAPS;
		return s >> 1;
	endfunction

	// One LFSR step per bit, bits shift in from the right
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Every parcel can start a slot, so each gets an opcode biased to the known set
	task automatic random_line(output logic [isa_pkg::LINE_W-1:0] line);
		logic [31:0] sel;
		logic [31:0] hi;
		logic [31:0] raw;
		logic [6:0] opc;
		for (int p = 0; p < LINE_PARCELS; p++) begin
			take_bits(3, sel);
			take_bits(9, hi);
			take_bits(7, raw);
			case (sel[2:0])
				3'd0: opc = isa_pkg::OP_BSR;
				3'd1: opc = isa_pkg::OP_JSR;
				3'd2: opc = isa_pkg::OP_BCC;
				3'd3: opc = isa_pkg::OP_RET;
				3'd4: opc = isa_pkg::OP_ADD;
				3'd5: opc = isa_pkg::OP_NOP;
				default: opc = raw[6:0];
			endcase
			line[p*isa_pkg::PARCEL_W +: isa_pkg::PARCEL_W] = {hi[8:0], opc};
		end
	endtask

	// ========================================================================
	// Reference model
	// ========================================================================

	// Parcels past the end of the line read as NOP filler
	function automatic logic [15:0] line_parcel(input logic [isa_pkg::LINE_W-1:0] line,
			input int p);
		if (p < LINE_PARCELS) return line[p*isa_pkg::PARCEL_W +: isa_pkg::PARCEL_W];
		return isa_pkg::NOP_PARCEL;
	endfunction

	task automatic model_fetch(input isa_pkg::pc_t pc, input logic [isa_pkg::LINE_W-1:0] line,
			input logic ssm, input logic kill, input logic bm, input isa_pkg::pc_t mpc,
			output expect_t e);
		logic [isa_pkg::ALIGN_W-1:0] bits;
		logic dead;
		logic found;
		isa_pkg::pc_t spc;
		logic [47:0] insn;
		logic [6:0] opc;
		for (int i = 0; i < 3 * isa_pkg::SLOTS; i++) begin
			bits[i*16 +: 16] = line_parcel(line, int'(pc[5:1]) + i);
		end
		dead = ((pc == m_prev_pc) && (bits == m_prev_bits)) || kill;
		for (int k = 0; k < isa_pkg::SLOTS; k++) begin
			spc = pc + 32'(6 * k);
			e.grp.slot[k].pc = spc;
			e.grp.slot[k].insn = bits[k*48 +: 48];
			e.grp.slot[k].valid = !dead && !(bm && (mpc > spc));
			e.grp.slot[k].ssm = 1'b0;
			if (ssm && (m_prev_ssm || (k > 0))) begin
				e.grp.slot[k].insn = {3{isa_pkg::NOP_PARCEL}};
				e.grp.slot[k].valid = 1'b0;
				e.grp.slot[k].ssm = 1'b1;
			end
		end
		m_prev_pc = pc;
		m_prev_bits = bits;
		m_prev_ssm = ssm;

		// First valid flow instruction wins, the fetch reset PC marks none found
		e.flow = {3'b000, isa_pkg::RESET_PC, isa_pkg::RESET_PC};
		found = 1'b0;
		for (int k = 0; k < isa_pkg::SLOTS; k++) begin
			insn = e.grp.slot[k].insn;
			opc = insn[6:0];
			spc = e.grp.slot[k].pc;
			if (!found && e.grp.slot[k].valid) begin
				found = 1'b1;
				if (opc == isa_pkg::OP_BSR || opc == isa_pkg::OP_JSR) begin
					e.flow.do_bsr = 1'b1;
					e.flow.do_call = 1'b1;
					e.flow.ret_pc = spc + 32'd6;
					e.flow.target = (opc == isa_pkg::OP_JSR) ? insn[47:16]
						: spc + {{8{insn[47]}}, insn[47:24]};
				end else if (opc == isa_pkg::OP_BCC) begin
					e.flow.do_bsr = 1'b1;
					e.flow.target = spc + {{8{insn[47]}}, insn[47:24]};
				end else if (opc == isa_pkg::OP_RET) begin
					e.flow.do_ret = 1'b1;
				end else begin
					found = 1'b0;
				end
			end
		end
		e.due = cycle + 2;
	endtask

	// ========================================================================
	// Driving and checking
	// ========================================================================

	// Holds fetch_i for one cycle, the caller sits 1 ns after a rising edge
	task automatic send_fetch(input isa_pkg::pc_t pc, input logic [isa_pkg::LINE_W-1:0] line,
			input logic ssm, input logic irq, input logic stomp, input logic bm,
			input isa_pkg::pc_t mpc);
		expect_t e;
		fetch_i = 1'b1;
		pc_i = pc;
		line_i = line;
		ssm_i = ssm;
		irq_i = irq;
		stomp_i = stomp;
		branchmiss_i = bm;
		miss_pc_i = mpc;
		model_fetch(pc, line, ssm, irq || stomp, bm, mpc, e);
		exp_q.push_back(e);
		@(posedge clk);
		#1;
		fetch_i = 1'b0;
	endtask

	task automatic compare_value(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("ERR %s exp %h got %h", name, exp, got);
		end
	endtask

	// Outputs settle after the rising edge, so they are sampled on the falling one
	always @(negedge clk) begin
		expect_t e;
		if (!rst_i && out_valid_o) begin
			assert (exp_q.size() > 0) else begin
				errors++;
				$display("Output group in cycle %0d with no fetch outstanding", cycle);
			end
			if (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				assert (cycle == e.due) else begin
					errors++;
					$display("Output group arrived in cycle %0d instead of %0d", cycle, e.due);
				end
				for (int k = 0; k < isa_pkg::SLOTS; k++) begin
					compare_value($sformatf("group_o.slot[%0d].insn", k),
						64'(e.grp.slot[k].insn), 64'(group_o.slot[k].insn));
					compare_value($sformatf("group_o.slot[%0d].pc", k),
						64'(e.grp.slot[k].pc), 64'(group_o.slot[k].pc));
					compare_value($sformatf("group_o.slot[%0d].valid", k),
						64'(e.grp.slot[k].valid), 64'(group_o.slot[k].valid));
					compare_value($sformatf("group_o.slot[%0d].ssm", k),
						64'(e.grp.slot[k].ssm), 64'(group_o.slot[k].ssm));
				end
				compare_value("do_bsr_o", 64'(e.flow.do_bsr), 64'(do_bsr_o));
				compare_value("do_call_o", 64'(e.flow.do_call), 64'(do_call_o));
				compare_value("do_ret_o", 64'(e.flow.do_ret), 64'(do_ret_o));
				compare_value("target_o", 64'(e.flow.target), 64'(target_o));
				compare_value("ret_pc_o", 64'(e.flow.ret_pc), 64'(ret_pc_o));
			end
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		logic [31:0] r;
		logic [isa_pkg::LINE_W-1:0] line;
		isa_pkg::pc_t pc;
		logic ssm_lvl;
		logic irq;
		logic stomp;
		logic bm;
		isa_pkg::pc_t mpc;
		{fetch_i, ssm_i, irq_i, stomp_i, branchmiss_i} = '0;
		pc_i = '0;
		line_i = '0;
		miss_pc_i = '0;
		rst_i = 1'b1;
		lfsr = LFSR_SEED;
		cycle = '0;
		errors = 0;
		checks = 0;
		m_prev_pc = '0;
		m_prev_bits = '0;
		m_prev_ssm = 1'b0;
		ssm_lvl = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_i = 1'b0;

		// Every parcel offset back to back, the high ones pull in NOP padding
		random_line(line);
		for (int off = 0; off < SWEEP_TESTS; off++) begin
			take_bits(32, r);
			pc = {r[31:6], 5'(off), 1'b0};
			send_fetch(pc, line, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		end

		// Repeat of one group, then a changed line and a changed PC
		// The sweep ends on the last parcel, so the change goes where slot 0 reads
		send_fetch(pc, line, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		line[isa_pkg::LINE_W-1 -: 9] = ~line[isa_pkg::LINE_W-1 -: 9];
		send_fetch(pc, line, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		send_fetch(pc, line, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		send_fetch(pc + 32'd2, line, 1'b0, 1'b0, 1'b0, 1'b0, '0);

		for (int t = 0; t < RANDOM_TESTS; t++) begin
			take_bits(3, r);
			if (r[2:0] != 3'd0) begin
				random_line(line);
				take_bits(31, r);
				pc = {r[30:0], 1'b0};
			end
			take_bits(3, r);
			if (r[2:0] == 3'd0) ssm_lvl = !ssm_lvl;
			take_bits(4, r);
			irq = (r[3:0] == 4'd0);
			take_bits(4, r);
			stomp = (r[3:0] == 4'd0);
			take_bits(2, r);
			bm = (r[1:0] == 2'd0);
			take_bits(5, r);
			mpc = pc + 32'(r[4:0]);
			send_fetch(pc, line, ssm_lvl, irq, stomp, bm, mpc);
			take_bits(2, r);
			repeat (r[1] ? int'(r[0]) + 1 : 0) begin
				@(posedge clk);
				#1;
			end
		end

		wait (exp_q.size() == 0);
		repeat (3) @(posedge clk);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, %0d groups never came out, errors %0d",
			cycle, exp_q.size(), errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule
